//--- Bender.yml
package:
  name: sfir_even_symmetric_systolic

sources:
  # design, in compile order
  - files:
      - sfir_pkg.sv
      - shift_reg.sv
      - sfir_even_symmetric_systolic_element.sv
      - sfir_round_sat.sv
      - sfir_even_symmetric_systolic_top.sv

  # testbench
  - target: test
    files:
      - sfir_checker.sv
      - tb_sfir_top.sv

//--- list.f
sfir_pkg.sv
shift_reg.sv
sfir_even_symmetric_systolic_element.sv
sfir_round_sat.sv
sfir_even_symmetric_systolic_top.sv
sfir_checker.sv
tb_sfir_top.sv

//--- sfir_checker.sv
`timescale 1ns/1ps

module sfir_checker
    import sfir_pkg::*;
(
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         en_i,
    input  logic signed [DATA_WIDTH-1:0] data_i,
    input  logic signed [ACC_WIDTH-1:0]  fir_i,
    input  logic signed [OUT_WIDTH-1:0]  y_i,
    input  logic                         sat_i,
    output int                           errors_o
);

    localparam int SPAN = 2 * TAP_NUM;  // taps of the full filter

    logic signed [DATA_WIDTH-1:0] hist [$];  // accepted samples, enabled cycles only

    string test_name = "none";
    bit    want_sat;
    bit    sat_seen;
    int    test_checks;
    int    test_errors;
    int    total_checks;
    int    total_errors;
    int    tests_done;
    int    tests_failed;

    assign errors_o = total_errors;

    // x is zero before the first accepted sample
    function automatic longint sample_at(int idx);
        if (idx < 0 || idx >= hist.size()) begin
            return 0;
        end
        return longint'(hist[idx]);
    endfunction

    // full-precision sum seen on fir_i once t+1 samples were accepted
    function automatic longint fir_model(int t);
        longint sum;
        int     base;
        sum  = 0;
        base = t - FIR_LATENCY;
        for (int k = 0; k < TAP_NUM; k++) begin
            sum += longint'(FIR_COEF[k])
                * (sample_at(base - k) + sample_at(base - (SPAN - 1) + k));
        end
        return sum;
    endfunction

    function automatic longint round_model(input longint s, output bit clip);
        longint r;
        longint hi;
        longint lo;
        hi   = (longint'(1) <<< (OUT_WIDTH - 1)) - 1;
        lo   = -(longint'(1) <<< (OUT_WIDTH - 1));
        r    = (s + (longint'(1) <<< (FRAC_SHIFT - 1))) >>> FRAC_SHIFT;
        clip = 1'b0;
        if (r > hi) begin
            r    = hi;
            clip = 1'b1;
        end else if (r < lo) begin
            r    = lo;
            clip = 1'b1;
        end
        return r;
    endfunction

    // twice the coefficient sum, the gain for a constant input
    function automatic longint dc_gain();
        longint g;
        g = 0;
        for (int k = 0; k < TAP_NUM; k++) begin
            g += 2 * longint'(FIR_COEF[k]);
        end
        return g;
    endfunction

    // true when every sample under the filter window has one value
    function automatic bit window_level(input int t, output longint level);
        int base;
        base  = t - FIR_LATENCY;
        level = sample_at(base);
        for (int i = 1; i < SPAN; i++) begin
            if (sample_at(base - i) != level) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic expect_value(string what, longint exp, longint act);
        test_checks++;
        total_checks++;
        if (exp != act) begin
            test_errors++;
            total_errors++;
            $display("[ERROR] %0t: test %s, %s expected %0d, got %0d",
                     $time, test_name, what, exp, act);
        end
    endtask

    task automatic start_test(string name, bit expect_sat);
        test_name   = name;
        want_sat    = expect_sat;
        sat_seen    = 1'b0;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test();
        if (want_sat && !sat_seen) begin
            test_errors++;
            total_errors++;
            $display("test %s: sat_o never went high although the input drives the sum off range",
                     test_name);
        end
        tests_done++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %-16s %5d checks, %0d errors, %s", test_name, test_checks, test_errors,
                 (test_errors == 0) ? "ok" : "failed");
    endtask

    task automatic report_totals();
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_done, tests_failed, total_checks, total_errors);
    endtask

    // outputs settle between edges, the inputs seen here go into the next edge
    always @(negedge clk_i) begin : sample_and_compare
        int     t;
        longint exp_fir;
        longint exp_y;
        bit     exp_sat;
        longint level;
        if (arst_n_i) begin
            t = hist.size() - 1;  // index of the last accepted sample
            if ($isunknown({fir_i, y_i, sat_i})) begin
                test_errors++;
                total_errors++;
                $display("test %s: an output of the filter is unknown at %0t", test_name, $time);
            end
            exp_fir = fir_model(t);
            exp_y   = round_model(fir_model(t - 1), exp_sat);  // output stage is one behind
            expect_value("fir_o", exp_fir, longint'(fir_i));
            expect_value("y_o", exp_y, longint'(y_i));
            expect_value("sat_o", longint'(exp_sat), longint'(sat_i));
            if (window_level(t, level)) begin
                expect_value("settled fir_o", level * dc_gain(), longint'(fir_i));
            end
            if (sat_i) begin
                sat_seen = 1'b1;
            end
            if (en_i) begin
                hist.push_back(data_i);
            end
        end
    end

endmodule

//--- sfir_even_symmetric_systolic_element.sv
`timescale 1ns/1ps

module sfir_even_symmetric_systolic_element
    import sfir_pkg::*;
(
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         en_i,
    input  logic signed [COEF_WIDTH-1:0] coef_i,
    input  sfir_casc_t                   casc_i,
    input  logic signed [DATA_WIDTH-1:0] zdata_i,
    output sfir_casc_t                   casc_o
);

    logic signed [DATA_WIDTH-1:0]   data_q1;
    logic signed [DATA_WIDTH-1:0]   data_q2;
    logic signed [DATA_WIDTH-1:0]   zdata_q;
    logic signed [PREADD_WIDTH-1:0] preadd_q;
    logic signed [PROD_WIDTH-1:0]   prod_q;
    logic signed [ACC_WIDTH-1:0]    sum_d;
    logic signed [ACC_WIDTH-1:0]    sum_q;

    // forward sample, two stages per tap
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            data_q1 <= '0;
            data_q2 <= '0;
        end else if (en_i) begin
            data_q1 <= casc_i.sample;
            data_q2 <= data_q1;
        end
    end

    // The mirrored sample is taken through one local register. With the
    // 2*TAP_NUM deep delay line this gives an even tap count, so the centre
    // pair does not collapse onto the same sample.
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            zdata_q <= '0;
        end else if (en_i) begin
            zdata_q <= zdata_i;
        end
    end

    assign sum_d = prod_q + casc_i.psum;  // sign-extended product

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            preadd_q <= '0;
            prod_q   <= '0;
            sum_q    <= '0;
        end else if (en_i) begin
            preadd_q <= data_q2 + zdata_q;  // symmetric pre-add
            prod_q   <= preadd_q * coef_i;
            sum_q    <= sum_d;
        end
    end

    assign casc_o.sample = data_q2;
    assign casc_o.psum   = sum_q;

    // like-signed operands must give a like-signed sum, else the
    // accumulator width chosen in the package is too small
    a_no_acc_overflow: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        en_i && (prod_q[PROD_WIDTH-1] == casc_i.psum[ACC_WIDTH-1])
            |-> (sum_d[ACC_WIDTH-1] == prod_q[PROD_WIDTH-1])
    ) else $error("cascade sum overflows ACC_WIDTH");

endmodule

//--- sfir_even_symmetric_systolic_top.sv
`timescale 1ns/1ps

module sfir_even_symmetric_systolic_top
    import sfir_pkg::*;
(
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         en_i,
    input  logic signed [DATA_WIDTH-1:0] data_i,
    output logic signed [ACC_WIDTH-1:0]  fir_o,
    output logic signed [OUT_WIDTH-1:0]  y_o,
    output logic                         sat_o
);

    sfir_casc_t                   casc [TAP_NUM+1];  // casc[i] feeds element i
    logic signed [DATA_WIDTH-1:0] zdata;

    assign casc[0].sample = data_i;
    assign casc[0].psum   = '0;  // chain starts empty

    shift_reg #(
        .DELAY(SHIFT_DELAY)
    ) i_shift_reg (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .en_i    (en_i),
        .data_i  (data_i),
        .data_o  (zdata)
    );

    for (genvar i = 0; i < TAP_NUM; i++) begin : g_tap
        sfir_even_symmetric_systolic_element i_element (
            .clk_i   (clk_i),
            .arst_n_i(arst_n_i),
            .en_i    (en_i),
            .coef_i  (FIR_COEF[i]),
            .casc_i  (casc[i]),
            .zdata_i (zdata),  // shared by every tap
            .casc_o  (casc[i+1])
        );
    end

    assign fir_o = casc[TAP_NUM].psum;  // full precision

    sfir_round_sat i_round_sat (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .en_i    (en_i),
        .acc_i   (casc[TAP_NUM].psum),
        .y_o     (y_o),
        .sat_o   (sat_o)
    );

endmodule

//--- sfir_pkg.sv
package sfir_pkg;

    // filter geometry
    localparam int TAP_NUM     = 4;  // systolic elements, filter has 2*TAP_NUM taps
    localparam int SHIFT_DELAY = 2 * TAP_NUM;

    // datapath widths
    localparam int DATA_WIDTH   = 16;
    localparam int COEF_WIDTH   = 16;
    localparam int PREADD_WIDTH = DATA_WIDTH + 1;
    localparam int PROD_WIDTH   = PREADD_WIDTH + COEF_WIDTH;
    localparam int ACC_WIDTH    = PROD_WIDTH + $clog2(TAP_NUM);  // 35 with the values above

    // output stage
    localparam int OUT_WIDTH  = 16;
    localparam int FRAC_SHIFT = 15;  // coefficients are Q15
    localparam int RND_WIDTH  = ACC_WIDTH + 1;  // headroom for the rounding add
    localparam int SHR_WIDTH  = RND_WIDTH - FRAC_SHIFT;

    localparam logic signed [RND_WIDTH-1:0] ROUND_HALF = 2 ** (FRAC_SHIFT - 1);
    localparam logic signed [OUT_WIDTH-1:0] OUT_MAX    = {1'b0, {(OUT_WIDTH - 1){1'b1}}};
    localparam logic signed [OUT_WIDTH-1:0] OUT_MIN    = {1'b1, {(OUT_WIDTH - 1){1'b0}}};

    // enabled cycles from data_i to fir_o, one more to y_o
    localparam int FIR_LATENCY     = TAP_NUM + 3;
    localparam int FIR_LATENCY_OUT = FIR_LATENCY + 1;

    typedef logic signed [COEF_WIDTH-1:0] coef_t;

    // Half of an even-symmetric low-pass in Q15, h[0] is the outermost tap.
    // DC gain is 2*sum(h) = 1.25, so a near full-scale constant input clips.
    // The response on fir_o, counted from the output of sample n, is
    //   y[n] = sum_k h[k] * (x[n-k] + x[n-(2*TAP_NUM-1)+k])
    localparam coef_t FIR_COEF [TAP_NUM] = '{
        -16'sd1536,
        16'sd2560,
        16'sd7168,
        16'sd12288
    };

    // fields passed from one element to the next
    typedef struct packed {
        logic signed [DATA_WIDTH-1:0] sample;  // forward sample, two cycles per element
        logic signed [ACC_WIDTH-1:0]  psum;    // partial sum
    } sfir_casc_t;

endpackage

//--- sfir_round_sat.sv
`timescale 1ns/1ps

module sfir_round_sat
    import sfir_pkg::*;
(
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         en_i,
    input  logic signed [ACC_WIDTH-1:0]  acc_i,
    output logic signed [OUT_WIDTH-1:0]  y_o,
    output logic                         sat_o
);

    logic signed [RND_WIDTH-1:0] rnd;
    logic signed [SHR_WIDTH-1:0] shr;
    logic signed [OUT_WIDTH-1:0] y_d;
    logic                        sat_d;

    assign rnd = acc_i + ROUND_HALF;  // round half up
    assign shr = SHR_WIDTH'(rnd >>> FRAC_SHIFT);

    // clamp to the signed output range
    always_comb begin
        y_d   = shr[OUT_WIDTH-1:0];
        sat_d = 1'b0;
        if (shr > OUT_MAX) begin
            y_d   = OUT_MAX;
            sat_d = 1'b1;
        end else if (shr < OUT_MIN) begin
            y_d   = OUT_MIN;
            sat_d = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            y_o   <= '0;
            sat_o <= 1'b0;
        end else if (en_i) begin
            y_o   <= y_d;
            sat_o <= sat_d;
        end
    end

    a_sat_on_rail: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        sat_o |-> (y_o == OUT_MAX) || (y_o == OUT_MIN)
    ) else $error("sat_o high but y_o %0d is not on a rail", y_o);

endmodule

//--- shift_reg.sv
`timescale 1ns/1ps

module shift_reg
    import sfir_pkg::*;
#(
    parameter int DELAY = SHIFT_DELAY
) (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         en_i,
    input  logic signed [DATA_WIDTH-1:0] data_i,
    output logic signed [DATA_WIDTH-1:0] data_o
);

    logic signed [DATA_WIDTH-1:0] taps_q [DELAY];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            taps_q <= '{default: '0};
        end else if (en_i) begin
            taps_q[0] <= data_i;
            for (int i = 1; i < DELAY; i++) begin
                taps_q[i] <= taps_q[i-1];  // one place per enabled cycle
            end
        end
    end

    assign data_o = taps_q[DELAY-1];  // mirrored-half sample

    // the enable gates every register of the filter, an X here corrupts all of them
    a_en_known: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        !$isunknown(en_i)
    ) else $error("en_i is unknown");

endmodule

//--- tb_sfir_top.sv
`timescale 1ns/1ps

module tb_sfir_top
    import sfir_pkg::*;
();

    localparam time CLK_PERIOD   = 100ns;
    localparam int  RESET_CYCLES = 2;
    localparam int  FLUSH        = FIR_LATENCY_OUT + SHIFT_DELAY;  // zeros after each test
    localparam int  NUM_TESTS    = 7;
    localparam int  ALT_BLOCK    = 16;  // samples per rail of the square wave

    typedef enum {PAT_IDLE, PAT_IMPULSE, PAT_CONST, PAT_RANDOM, PAT_ALT} pattern_e;

    typedef struct {
        string                        name;
        int                           count;  // accepted samples, idle cycles for PAT_IDLE
        pattern_e                     pattern;
        logic signed [DATA_WIDTH-1:0] amp;
        bit                           gaps;   // random low cycles on en
        bit                           expect_sat;
    } stim_t;

    stim_t stim_table [NUM_TESTS] = '{
        '{"post_reset",     4,   PAT_IDLE,    16'sd0,      1'b0, 1'b0},
        '{"impulse",        4,   PAT_IMPULSE, 16'sd10000,  1'b0, 1'b0},
        '{"impulse_gaps",   4,   PAT_IMPULSE, -16'sd20000, 1'b1, 1'b0},
        '{"constant",       32,  PAT_CONST,   16'sd8000,   1'b0, 1'b0},
        '{"constant_gaps",  32,  PAT_CONST,   -16'sd12000, 1'b1, 1'b0},
        '{"random_gaps",    200, PAT_RANDOM,  16'sd0,      1'b1, 1'b0},
        '{"full_scale_alt", 64,  PAT_ALT,     16'sd0,      1'b0, 1'b1}
    };

    logic                         clk = 1'b0;
    logic                         arst_n;
    logic                         en;
    logic signed [DATA_WIDTH-1:0] data;
    logic signed [ACC_WIDTH-1:0]  fir;
    logic signed [OUT_WIDTH-1:0]  y;
    logic                         sat;
    int                           errors;

    always #(CLK_PERIOD / 2) clk = ~clk;

    sfir_even_symmetric_systolic_top i_dut (
        .clk_i   (clk),
        .arst_n_i(arst_n),
        .en_i    (en),
        .data_i  (data),
        .fir_o   (fir),
        .y_o     (y),
        .sat_o   (sat)
    );

    sfir_checker i_checker (
        .clk_i   (clk),
        .arst_n_i(arst_n),
        .en_i    (en),
        .data_i  (data),
        .fir_i   (fir),
        .y_i     (y),
        .sat_i   (sat),
        .errors_o(errors)
    );

    function automatic logic signed [DATA_WIDTH-1:0] sample_for(stim_t s, int k);
        case (s.pattern)
            PAT_IMPULSE: return (k == 0) ? s.amp : '0;
            PAT_CONST:   return s.amp;
            PAT_RANDOM:  return DATA_WIDTH'($urandom);
            PAT_ALT: begin
                if ((k / ALT_BLOCK) % 2 == 0) begin
                    return {1'b0, {(DATA_WIDTH - 1){1'b1}}};  // positive full scale
                end
                return {1'b1, {(DATA_WIDTH - 1){1'b0}}};
            end
            default:     return '0;
        endcase
    endfunction

    // clock cycles of the whole table without enable gaps
    function automatic int total_cycles();
        int n;
        n = RESET_CYCLES + 2;
        foreach (stim_table[i]) begin
            n += stim_table[i].count + 2;
            if (stim_table[i].pattern != PAT_IDLE) begin
                n += FLUSH;
            end
        end
        return n;
    endfunction

    task automatic run_test(stim_t s);
        int                           accepted;
        bit                           drive_en;
        logic signed [DATA_WIDTH-1:0] drive_data;
        i_checker.start_test(s.name, s.expect_sat);
        if (s.pattern == PAT_IDLE) begin
            repeat (s.count) begin
                @(posedge clk);
                en   <= 1'b0;
                data <= '0;
            end
        end else begin
            accepted = 0;
            while (accepted < s.count + FLUSH) begin
                @(posedge clk);
                drive_en = !s.gaps || (($urandom % 4) != 0);
                if (accepted >= s.count) begin
                    drive_en = 1'b1;  // flush runs without gaps
                end
                if (!drive_en) begin
                    drive_data = DATA_WIDTH'($urandom);  // must be ignored
                end else if (accepted < s.count) begin
                    drive_data = sample_for(s, accepted);
                end else begin
                    drive_data = '0;
                end
                en   <= drive_en;
                data <= drive_data;
                if (drive_en) begin
                    accepted++;
                end
            end
        end
        @(posedge clk);
        en <= 1'b0;
        @(posedge clk);  // last state compared on the negedge before
        i_checker.finish_test();
    endtask

    initial begin : watchdog
        int limit;
        limit = 2 * total_cycles() + 100;
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", limit);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin : main
        void'($urandom(32'hbb53));
        arst_n = 1'b0;
        en     = 1'b0;
        data   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        foreach (stim_table[i]) begin
            run_test(stim_table[i]);
        end
        i_checker.report_totals();
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
